/* build_sim.sh */
#!/usr/bin/env bash
# compile the UART transmitter testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --timescale 1ns/100ps \
	--top-module tx_top_tb --Mdir obj_dir -o sim_tx_top \
	-f tx_top.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_tx_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qxF '** PASS **' <<< "$sim_out"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* src/baud_generator.sv */
`include "uart_params.svh"

module baud_generator (
	input  logic               clk,        // system clock
	input  logic               i_rst_n,    // async reset, active low
	input  uart_pkg::baud_div_t i_div,     // bit period minus one
	input  logic               i_sync,     // restart count at frame start
	output logic               o_bit_tick  // one cycle pulse per bit period
);

	import uart_pkg::*;

	baud_div_t cnt_q; // clocks left in current bit

	// down counter reloads on frame start or when it runs out
	// so a new divisor is picked up at the next frame start
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_q <= '0;
		end else if (i_sync) begin
			cnt_q <= i_div;            // align bit boundaries to the frame
		end else if (cnt_q == '0) begin
			cnt_q <= i_div;            // next bit period
		end else begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// tick on the last clock of each bit period
	assign o_bit_tick = (cnt_q == '0);

endmodule

/* src/tx_fifo.sv */
`include "uart_params.svh"

module tx_fifo #(
	parameter int DEPTH_LOG2 = `UART_FIFO_DEPTH_LOG2 // log2 of entry count
) (
	input  logic                  clk,         // system clock
	input  logic                  i_rst_n,     // async reset, active low
	input  logic                  i_push,      // write one byte
	input  uart_pkg::tx_byte_t    i_push_data, // byte to write
	input  logic                  i_pop,       // drop the head entry
	output uart_pkg::tx_byte_t    o_head,      // oldest byte, valid when not empty
	output logic                  o_empty,     // no entries
	output logic                  o_full,      // all entries in use
	output logic [DEPTH_LOG2:0]   o_level      // number of entries held
);

	import uart_pkg::*;

	localparam int DEPTH = 1 << DEPTH_LOG2;

	tx_byte_t mem [DEPTH];             // byte storage, no reset needed

	logic [DEPTH_LOG2:0] wr_ptr_q;     // msb is the wrap flag
	logic [DEPTH_LOG2:0] rd_ptr_q;     // msb is the wrap flag
	logic [DEPTH_LOG2:0] level_q;      // entry count
	logic                do_push;      // accepted write
	logic                do_pop;       // accepted read

	assign do_push = i_push && !o_full;  // overflow is dropped
	assign do_pop  = i_pop && !o_empty;  // underflow is dropped

	// storage write, head shows it on the next cycle
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr_q[DEPTH_LOG2-1:0]] <= i_push_data;
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   level_q <= level_q + 1'b1;
				2'b01:   level_q <= level_q - 1'b1;
				default: level_q <= level_q;  // none, or push and pop together
			endcase
		end
	end

	// first word fall through, head read straight from storage
	assign o_head = mem[rd_ptr_q[DEPTH_LOG2-1:0]];

	// same index, wrap flags equal means empty and different means full
	assign o_empty = (wr_ptr_q == rd_ptr_q);
	assign o_full  = (wr_ptr_q[DEPTH_LOG2] != rd_ptr_q[DEPTH_LOG2]) &&
	                 (wr_ptr_q[DEPTH_LOG2-1:0] == rd_ptr_q[DEPTH_LOG2-1:0]);
	assign o_level = level_q;

endmodule

/* src/tx_serializer.sv */
`include "uart_params.svh"

module tx_serializer (
	input  logic               clk,           // system clock
	input  logic               i_rst_n,       // async reset, active low
	input  logic               i_tx_en,       // allow new frames
	input  logic               i_parity_en,   // add even parity bit
	input  logic               i_empty,       // fifo has no data
	input  uart_pkg::tx_byte_t i_head,        // fifo head byte
	input  logic               i_bit_tick,    // end of current bit period
	output logic               o_pop,         // take the fifo head
	output logic               o_frame_start, // restart baud count
	output logic               o_busy,        // frame in progress
	output logic               o_serial_out   // tx line, idle high
);

	import uart_pkg::*;

	localparam int CNT_W = $clog2(`UART_DATA_W);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`UART_DATA_W - 1);

	tx_state_e        state_q;   // frame position
	tx_byte_t         shift_q;   // remaining data bits, lsb goes next
	logic             parity_q;  // even parity of the latched byte
	logic [CNT_W-1:0] bit_cnt_q; // data bits already sent after bit 0

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q      <= TX_IDLE;
			shift_q      <= '0;
			parity_q     <= 1'b0;
			bit_cnt_q    <= '0;
			o_pop        <= 1'b0;
			o_busy       <= 1'b0;
			o_serial_out <= 1'b1;    // line idles high
		end else begin
			o_pop <= 1'b0;           // single cycle pulse
			case (state_q)
				TX_IDLE: begin
					o_serial_out <= 1'b1;
					if (i_tx_en && !i_empty) begin
						shift_q   <= i_head;     // latch before the pop
						parity_q  <= ^i_head;    // even parity
						bit_cnt_q <= '0;
						o_pop     <= 1'b1;
						o_busy    <= 1'b1;
						state_q   <= TX_START;
					end
				end
				TX_START: begin
					if (o_pop) begin
						o_serial_out <= 1'b0;    // start bit after the pop cycle
					end else if (i_bit_tick) begin
						o_serial_out <= shift_q[0];  // data bit 0
						shift_q      <= {1'b0, shift_q[`UART_DATA_W-1:1]};
						state_q      <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (i_bit_tick) begin
						if (bit_cnt_q == LAST_BIT) begin
							if (i_parity_en) begin
								o_serial_out <= parity_q;
								state_q      <= TX_PARITY;
							end else begin
								o_serial_out <= 1'b1;    // straight to stop bit
								state_q      <= TX_STOP;
							end
						end else begin
							o_serial_out <= shift_q[0];
							shift_q      <= {1'b0, shift_q[`UART_DATA_W-1:1]};
							bit_cnt_q    <= bit_cnt_q + 1'b1;
						end
					end
				end
				TX_PARITY: begin
					if (i_bit_tick) begin
						o_serial_out <= 1'b1;    // stop bit
						state_q      <= TX_STOP;
					end
				end
				TX_STOP: begin
					if (i_bit_tick) begin
						o_busy  <= 1'b0;         // frame done
						state_q <= TX_IDLE;
					end
				end
				default: begin
					o_serial_out <= 1'b1;
					o_busy       <= 1'b0;
					state_q      <= TX_IDLE;
				end
			endcase
		end
	end

	// baud count restarts together with the pop
	assign o_frame_start = o_pop;

endmodule

/* src/tx_top.sv */
`include "uart_params.svh"

module tx_top (
	input  logic                clk,          // 48MHz system clock
	input  logic                i_rst_n,      // async reset, active low
	input  logic                i_wb_cyc,     // wishbone cycle
	input  logic                i_wb_stb,     // wishbone strobe
	input  logic                i_wb_we,      // wishbone write
	input  uart_pkg::reg_addr_e i_wb_adr,     // wishbone word address
	input  uart_pkg::tx_byte_t  i_wb_dat,     // wishbone write data
	output uart_pkg::tx_byte_t  o_wb_dat,     // wishbone read data
	output logic                o_wb_ack,     // wishbone acknowledge
	output logic                o_serial_out  // uart tx line
);

	import uart_pkg::*;

	logic                           push;        // regs to fifo write
	tx_byte_t                       push_data;
	logic                           pop;         // serializer takes head
	tx_byte_t                       head;
	logic                           empty;
	logic                           full;
	logic [`UART_FIFO_DEPTH_LOG2:0] level;
	logic                           busy;
	logic                           tx_en;
	logic                           parity_en;
	baud_div_t                      div;
	logic                           frame_start; // baud restart
	logic                           bit_tick;

	wb_tx_regs regs_i (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_adr    (i_wb_adr),
		.i_wb_dat    (i_wb_dat),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack),
		.i_full      (full),
		.i_empty     (empty),
		.i_level     (level),
		.i_busy      (busy),
		.o_push      (push),
		.o_push_data (push_data),
		.o_tx_en     (tx_en),
		.o_parity_en (parity_en),
		.o_div       (div)
	);

	tx_fifo #(
		.DEPTH_LOG2 (`UART_FIFO_DEPTH_LOG2)
	) fifo_i (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_push      (push),
		.i_push_data (push_data),
		.i_pop       (pop),
		.o_head      (head),
		.o_empty     (empty),
		.o_full      (full),
		.o_level     (level)
	);

	baud_generator baud_i (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_div      (div),
		.i_sync     (frame_start),
		.o_bit_tick (bit_tick)
	);

	tx_serializer ser_i (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_tx_en       (tx_en),
		.i_parity_en   (parity_en),
		.i_empty       (empty),
		.i_head        (head),
		.i_bit_tick    (bit_tick),
		.o_pop         (pop),
		.o_frame_start (frame_start),
		.o_busy        (busy),
		.o_serial_out  (o_serial_out)
	);

endmodule

/* src/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// data path width, one byte per frame
`define UART_DATA_W 8

// log2 of tx fifo depth, 16 entries
`define UART_FIFO_DEPTH_LOG2 4

// baud divisor width
`define UART_DIV_W 16

// 9600 bit/s from a 48 MHz clk
`define UART_DEFAULT_DIV 4999

// wishbone word address width
`define UART_ADDR_W 3

`endif

/* src/uart_pkg.sv */
`include "uart_params.svh"

package uart_pkg;

	typedef logic [`UART_DATA_W-1:0] tx_byte_t;  // one data byte
	typedef logic [`UART_DIV_W-1:0]  baud_div_t; // bit period minus one, in clk cycles

	typedef enum logic [`UART_ADDR_W-1:0] {
		REG_DATA   = 'd0, // write pushes a byte into the fifo
		REG_STATUS = 'd1, // {level, full, empty, busy}
		REG_CTRL   = 'd2, // {parity_en, tx_en}
		REG_DIV_LO = 'd3, // divisor bits 7:0
		REG_DIV_HI = 'd4  // divisor bits 15:8
	} reg_addr_e;

	typedef enum logic [2:0] {
		TX_IDLE,   // line high, waiting for data
		TX_START,  // start bit, line low
		TX_DATA,   // eight data bits lsb first
		TX_PARITY, // even parity bit
		TX_STOP    // stop bit, line high
	} tx_state_e;

endpackage

/* src/wb_tx_regs.sv */
`include "uart_params.svh"

module wb_tx_regs (
	input  logic                            clk,         // system clock
	input  logic                            i_rst_n,     // async reset, active low
	input  logic                            i_wb_cyc,    // bus cycle
	input  logic                            i_wb_stb,    // strobe
	input  logic                            i_wb_we,     // write
	input  uart_pkg::reg_addr_e             i_wb_adr,    // word address
	input  uart_pkg::tx_byte_t              i_wb_dat,    // write data
	output uart_pkg::tx_byte_t              o_wb_dat,    // read data
	output logic                            o_wb_ack,    // acknowledge
	input  logic                            i_full,      // fifo full
	input  logic                            i_empty,     // fifo empty
	input  logic [`UART_FIFO_DEPTH_LOG2:0]  i_level,     // fifo entry count
	input  logic                            i_busy,      // serializer busy
	output logic                            o_push,      // fifo write strobe
	output uart_pkg::tx_byte_t              o_push_data, // fifo write data
	output logic                            o_tx_en,     // transmit enable
	output logic                            o_parity_en, // parity enable
	output uart_pkg::baud_div_t             o_div        // baud divisor
);

	import uart_pkg::*;

	logic     req;       // new request, not the cycle after an ack
	logic     data_wr;   // write to the data register
	logic     stall;     // data write held off while fifo full
	tx_byte_t rd_mux;    // read data for the addressed register
	tx_byte_t status;    // status byte

	assign req     = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign data_wr = i_wb_we && (i_wb_adr == REG_DATA);
	assign stall   = data_wr && i_full;

	// {level, full, empty, busy}
	assign status = {i_level, i_full, i_empty, i_busy};

	always_comb begin
		case (i_wb_adr)
			REG_STATUS: rd_mux = status;
			REG_CTRL:   rd_mux = {6'b0, o_parity_en, o_tx_en};
			REG_DIV_LO: rd_mux = o_div[7:0];
			REG_DIV_HI: rd_mux = o_div[15:8];
			default:    rd_mux = '0;     // data reg and unmapped read 0
		endcase
	end

	// registered ack, one cycle after strobe unless stalled
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wb_ack <= 1'b0;
		end else begin
			o_wb_ack <= req && !stall;
		end
	end

	// read data captured with the ack
	always_ff @(posedge clk) begin
		if (req && !stall) begin
			o_wb_dat <= rd_mux;
		end
	end

	// control and divisor update on the ack edge
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_tx_en     <= 1'b0;
			o_parity_en <= 1'b0;
			o_div       <= `UART_DIV_W'(`UART_DEFAULT_DIV);
		end else if (o_wb_ack && i_wb_we) begin
			case (i_wb_adr)
				REG_CTRL: begin
					o_tx_en     <= i_wb_dat[0];
					o_parity_en <= i_wb_dat[1];
				end
				REG_DIV_LO: o_div[7:0]  <= i_wb_dat;
				REG_DIV_HI: o_div[15:8] <= i_wb_dat;
				default: ;                   // data and read-only regs
			endcase
		end
	end

	// push in the ack cycle, host still holds the byte
	assign o_push      = o_wb_ack && i_wb_cyc && i_wb_stb && data_wr;
	assign o_push_data = i_wb_dat;

endmodule

/* tx_top.f */
+incdir+src
src/uart_pkg.sv
src/baud_generator.sv
src/tx_fifo.sv
src/tx_serializer.sv
src/wb_tx_regs.sv
src/tx_top.sv
verification/tx_line_monitor.sv
verification/tx_top_tb.sv

/* verification/tx_line_monitor.sv */
module tx_line_monitor (
	input  logic                clk,         // testbench clock
	input  logic                i_serial,    // uart tx line
	input  uart_pkg::baud_div_t i_div,       // divisor the host programmed
	input  logic                i_parity_en, // frame carries a parity bit
	output logic                o_valid,     // one clock pulse per decoded frame
	output uart_pkg::tx_byte_t  o_data,      // decoded data byte
	output logic                o_parity,    // sampled parity bit
	output logic                o_stop       // sampled stop bit
);
	timeunit 1ns;
	timeprecision 100ps;

	import uart_pkg::*;

	// sampling on the falling clock edge, the line only moves on the rising one
	initial begin : sample_loop
		int       bit_clks;
		tx_byte_t data;
		o_valid  = 1'b0;
		o_data   = '0;
		o_parity = 1'b0;
		o_stop   = 1'b0;
		data     = '0;
		forever begin
			@(negedge clk);
			if (i_serial == 1'b0) begin                 // first low sample of a start bit
				bit_clks = int'(i_div) + 1;
				repeat (bit_clks / 2) @(negedge clk);   // move to mid start bit
				if (i_serial == 1'b0) begin             // ignore a glitch
					for (int i = 0; i < 8; i++) begin
						repeat (bit_clks) @(negedge clk);
						data[i] = i_serial;             // lsb first
					end
					if (i_parity_en) begin
						repeat (bit_clks) @(negedge clk);
						o_parity = i_serial;
					end else begin
						o_parity = 1'b0;
					end
					repeat (bit_clks) @(negedge clk);
					o_stop  = i_serial;
					o_data  = data;
					o_valid = 1'b1;                     // seen by the next rising edge
					@(negedge clk);
					o_valid = 1'b0;
					// still mid stop bit here, so the search for the next start is safe
				end
			end
		end
	end

endmodule

/* verification/tx_top_tb.sv */
`include "uart_params.svh"

module tx_top_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import uart_pkg::*;

	typedef logic [`UART_FIFO_DEPTH_LOG2:0] fifo_level_t;

	localparam int        FIFO_DEPTH     = 1 << `UART_FIFO_DEPTH_LOG2;
	localparam baud_div_t TEST_DIV       = 16'd9;                // 10 clocks per bit
	localparam int        BIT_CLKS       = int'(TEST_DIV) + 1;
	localparam int        TOTAL_FRAMES   = 8 + 8 + (FIFO_DEPTH + 8) + 5;
	localparam int        TIMEOUT_CYCLES = 2 * TOTAL_FRAMES * 11 * BIT_CLKS + 2000;

	logic      clk;
	logic      rst_n;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	reg_addr_e wb_adr;
	tx_byte_t  wb_dat;
	tx_byte_t  wb_rdat;
	logic      wb_ack;
	logic      serial_out;
	logic      mon_parity_en;
	logic      mon_valid;
	tx_byte_t  mon_data;
	logic      mon_parity;
	logic      mon_stop;
	tx_byte_t  model_q[$];     // bytes written but not yet seen on the line
	int        seed;
	int        err_cnt;
	int        chk_cnt;
	int        rx_count;       // frames decoded by the monitor
	int        sent_count;     // data writes issued
	int        cycle_cnt;

	tx_top dut_i (
		.clk          (clk),
		.i_rst_n      (rst_n),
		.i_wb_cyc     (wb_cyc),
		.i_wb_stb     (wb_stb),
		.i_wb_we      (wb_we),
		.i_wb_adr     (wb_adr),
		.i_wb_dat     (wb_dat),
		.o_wb_dat     (wb_rdat),
		.o_wb_ack     (wb_ack),
		.o_serial_out (serial_out)
	);

	tx_line_monitor mon_i (
		.clk         (clk),
		.i_serial    (serial_out),
		.i_div       (TEST_DIV),
		.i_parity_en (mon_parity_en),
		.o_valid     (mon_valid),
		.o_data      (mon_data),
		.o_parity    (mon_parity),
		.o_stop      (mon_stop)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;                // 8 ns period

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_byte(input tx_byte_t got, input tx_byte_t exp, input string what);
		chk_cnt = chk_cnt + 1;
		if (got !== exp) begin
			$display("error at %0t: %s got %02h expected %02h", $time, what, got, exp);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic check_reg(input tx_byte_t got, input tx_byte_t exp, input string what);
		chk_cnt = chk_cnt + 1;
		if (got !== exp) begin
			$display("error at %0t: register %s read %02h expected %02h", $time, what, got, exp);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		chk_cnt = chk_cnt + 1;
		if (got !== exp) begin
			$display("error at %0t: %s got %b expected %b", $time, what, got, exp);
			err_cnt = err_cnt + 1;
		end
	endtask

	// status layout {level, full, empty, busy}
	function automatic tx_byte_t pack_status(input fifo_level_t level, input logic full,
	                                         input logic empty, input logic busy);
		return {level, full, empty, busy};
	endfunction

	// each decoded frame is matched against the oldest pending byte
	always @(posedge clk) begin : frame_check
		tx_byte_t exp_byte;
		if (mon_valid) begin
			if (model_q.size() == 0) begin
				$display("frame %02h appeared on the line with no byte pending", mon_data);
				err_cnt = err_cnt + 1;
			end else begin
				exp_byte = model_q.pop_front();
				check_byte(mon_data, exp_byte, "line data");
				check_bit(mon_stop, 1'b1, "stop bit");
				if (mon_parity_en) begin
					check_bit(mon_parity, ^exp_byte, "parity bit");  // even parity
				end
			end
			rx_count = rx_count + 1;
		end
	end

	// ack sampled mid cycle and bus released 1 ns after the completing edge
	task automatic wait_ack(output tx_byte_t rdata);
		@(negedge clk);
		while (wb_ack !== 1'b1) @(negedge clk);
		rdata = wb_rdat;
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input reg_addr_e adr, input tx_byte_t dat);
		tx_byte_t unused;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b1;
		wb_adr = adr;
		wb_dat = dat;
		wait_ack(unused);
	endtask

	task automatic wb_read(input reg_addr_e adr, output tx_byte_t dat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		wait_ack(dat);
	endtask

	task automatic send_bytes(input int n);
		int       rnd;
		tx_byte_t b;
		for (int i = 0; i < n; i++) begin
			rnd = $random(seed);
			b   = rnd[7:0];
			model_q.push_back(b);        // queued before the write can reach the line
			wb_write(REG_DATA, b);
			sent_count = sent_count + 1;
		end
	endtask

	task automatic wait_drain();
		while (rx_count < sent_count) begin
			@(posedge clk);
			#1;
		end
	endtask

	// poll until the serializer is done and the fifo is empty
	task automatic wait_idle();
		tx_byte_t st;
		st = 8'h01;
		while (st[0] || !st[1]) wb_read(REG_STATUS, st);
	endtask

	task automatic watch_line_idle(input int n);
		logic saw_low;
		saw_low = 1'b0;
		repeat (n) begin
			@(negedge clk);
			if (serial_out == 1'b0) saw_low = 1'b1;
		end
		check_bit(saw_low, 1'b0, "line low while tx disabled");
		@(posedge clk);
		#1;
	endtask

	task automatic finish_test(input string name, input int errs0);
		if (model_q.size() != 0) begin
			$display("%s: %0d written bytes never appeared on the line", name, model_q.size());
			err_cnt = err_cnt + 1;
		end
		if (rx_count != sent_count) begin
			$display("%s: %0d frames seen for %0d bytes written", name, rx_count, sent_count);
			err_cnt = err_cnt + 1;
		end
		if (err_cnt == errs0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, err_cnt - errs0);
		end
	endtask

	task automatic test_regs();
		int       errs0;
		int       rnd;
		tx_byte_t val;
		tx_byte_t lo;
		tx_byte_t hi;
		errs0 = err_cnt;
		wb_read(REG_STATUS, val);
		check_reg(val, pack_status('0, 1'b0, 1'b1, 1'b0), "status after reset");
		rnd = $random(seed);
		wb_write(REG_CTRL, {6'b0, rnd[1:0]});
		wb_read(REG_CTRL, val);
		check_reg(val, {6'b0, rnd[1:0]}, "ctrl");
		rnd = $random(seed);
		lo  = rnd[7:0];
		hi  = rnd[15:8];
		wb_write(REG_DIV_LO, lo);
		wb_write(REG_DIV_HI, hi);
		wb_read(REG_DIV_LO, val);
		check_reg(val, lo, "div_lo");
		wb_read(REG_DIV_HI, val);
		check_reg(val, hi, "div_hi");
		wb_write(REG_CTRL, 8'h00);       // transmit off for the next test
		finish_test("register read-back", errs0);
	endtask

	task automatic run_frames(input string name, input tx_byte_t ctrl, input int n);
		int errs0;
		errs0 = err_cnt;
		mon_parity_en = ctrl[1];
		wb_write(REG_CTRL, ctrl);
		send_bytes(n);
		wait_drain();
		wait_idle();
		finish_test(name, errs0);
	endtask

	task automatic test_enable_gate();
		int       errs0;
		tx_byte_t val;
		errs0 = err_cnt;
		mon_parity_en = 1'b0;
		wb_write(REG_CTRL, 8'h00);
		send_bytes(5);
		watch_line_idle(2 * 11 * BIT_CLKS);
		wb_read(REG_STATUS, val);
		check_reg(val, pack_status(fifo_level_t'(5), 1'b0, 1'b0, 1'b0), "status while gated");
		wb_write(REG_CTRL, 8'h01);
		wait_drain();
		repeat (BIT_CLKS) @(posedge clk);  // rest of the last stop bit
		#1;
		wb_read(REG_STATUS, val);
		check_reg(val, pack_status('0, 1'b0, 1'b1, 1'b0), "status after drain");
		finish_test("enable gating and status", errs0);
	endtask

	initial begin
		$timeformat(-9, 1, " ns", 0);
		seed          = 32'h7a75;
		err_cnt       = 0;
		chk_cnt       = 0;
		rx_count      = 0;
		sent_count    = 0;
		cycle_cnt     = 0;
		rst_n         = 1'b0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = REG_DATA;
		wb_dat        = '0;
		mon_parity_en = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_regs();
		wb_write(REG_DIV_LO, TEST_DIV[7:0]);   // short bit time for all frame tests
		wb_write(REG_DIV_HI, TEST_DIV[15:8]);
		run_frames("plain frames", 8'h01, 8);
		run_frames("even parity", 8'h03, 8);
		run_frames("back-pressure", 8'h01, FIFO_DEPTH + 8);  // overfills the fifo
		test_enable_gate();

		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
